//--- testbench/stimulus_packets.txt
# P line columns are phase queue beats first_data last_strb with the last two in hex
# E line columns are phase count and then the queue order of the drained packets
# phase 0 round robin from queue 0 with queue 2 left empty
P 0 0 3 00000000a0000000 0f
P 0 0 2 00000000a0000100 ff
P 0 1 4 00000000a1000000 03
P 0 3 1 00000000a3000000 01
P 0 3 5 00000000a3000100 7f
P 0 4 2 00000000a4000000 ff
E 0 6 0 1 3 4 0 3
# phase 1 fills queue 2 to depth minus 1
P 1 2 8 00000000b2000000 ff
P 1 2 7 00000000b2000100 1f
E 1 2 2 2
# phase 2 mixed lengths with the turn starting at queue 4
P 2 4 6 00000000c4000000 3f
P 2 0 3 00000000c0000000 ff
P 2 2 1 00000000c2000000 80
P 2 1 7 00000000c1000000 0f
P 2 1 7 00000000c1000100 07
E 2 5 4 0 1 2 1

//--- flist.f
source/turbo_pkg.sv
source/ingress_fifo.sv
source/egress_arbiter.sv
source/ualink_aggregator_top.sv
testbench/tb_clock_gen.sv
testbench/tb_top.sv

//--- Makefile
# Verilator build and run of the stream aggregator testbench

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module tb_top \
		-Mdir obj_dir -o tb_top_sim

run: compile
	./obj_dir/tb_top_sim 2>&1 | tee sim.log
	@if grep -q "Verification failed" sim.log; then \
		echo "simulation reported failure, see sim.log"; exit 1; \
	elif ! grep -q "Verification passed" sim.log; then \
		echo "simulation ended without a verdict, see sim.log"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

.PHONY: all compile run clean

//--- testbench/tb_top.sv
//******************************
// testbench for the stream aggregator, stimulus in testbench/stimulus_packets.txt
// each phase loads queues with master tready low, then drains at random tready
// a phase's packets per queue must fit in depth minus 1 beats
//******************************
`timescale 1ns/10ps
`default_nettype none

module tb_top
   import turbo_pkg::*;
();

   localparam int NUM_QUEUES      = 5;
   localparam int FIFO_DEPTH_BITS = 4;
   localparam int DEPTH           = 1 << FIFO_DEPTH_BITS;

   logic   axi_aclk;
   logic   axi_resetn;
   tdata_t s_axis_tdata  [NUM_QUEUES];
   tstrb_t s_axis_tstrb  [NUM_QUEUES];
   tuser_t s_axis_tuser  [NUM_QUEUES];
   logic   s_axis_tvalid [NUM_QUEUES];
   logic   s_axis_tready [NUM_QUEUES];
   logic   s_axis_tlast  [NUM_QUEUES];
   tdata_t m_axis_tdata;
   tstrb_t m_axis_tstrb;
   tuser_t m_axis_tuser;
   logic   m_axis_tvalid;
   logic   m_axis_tready;
   logic   m_axis_tlast;

   // packet lines of the stimulus file
   int     pkt_phase [$];
   int     pkt_queue [$];
   int     pkt_beats [$];
   tdata_t pkt_first [$];
   tstrb_t pkt_strb  [$];
   int     ord_phase [$];  // expected-order lines, one entry per packet
   int     ord_queue [$];

   // beats expected on the master port in the current phase
   tdata_t exp_data [$];
   tstrb_t exp_strb [$];
   tuser_t exp_user [$];
   logic   exp_last [$];

   int          num_phases      = 0;
   int          total_beats     = 0;
   int          value_errors    = 0;
   int          protocol_errors = 0;
   int          cycle_count     = 0;
   int          cycle_limit     = 500;
   logic [31:0] lfsr_state      = 32'hb377ed21;

   tb_clock_gen #(
      .PERIOD_NS    (4),
      .RESET_CYCLES (8)
   ) i_clock_gen (
      .axi_aclk   (axi_aclk),
      .axi_resetn (axi_resetn)
   );

   ualink_aggregator_top #(
      .NUM_QUEUES      (NUM_QUEUES),
      .FIFO_DEPTH_BITS (FIFO_DEPTH_BITS)
   ) i_dut (
      .axi_aclk      (axi_aclk),
      .axi_resetn    (axi_resetn),
      .s_axis_tdata  (s_axis_tdata),
      .s_axis_tstrb  (s_axis_tstrb),
      .s_axis_tuser  (s_axis_tuser),
      .s_axis_tvalid (s_axis_tvalid),
      .s_axis_tready (s_axis_tready),
      .s_axis_tlast  (s_axis_tlast),
      .m_axis_tdata  (m_axis_tdata),
      .m_axis_tstrb  (m_axis_tstrb),
      .m_axis_tuser  (m_axis_tuser),
      .m_axis_tvalid (m_axis_tvalid),
      .m_axis_tready (m_axis_tready),
      .m_axis_tlast  (m_axis_tlast)
   );

   always @(posedge axi_aclk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= cycle_limit) begin
         $display("timeout after %0d cycles, a handshake never completed", cycle_count);
         $display("Verification failed");
         $finish;
      end
   end

   // taps 32 22 2 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      logic fb;
      fb = s[31] ^ s[21] ^ s[1] ^ s[0];
      return {s[30:0], fb};
   endfunction

   task automatic compare_value(input string name, input logic [63:0] expv,
                                input logic [63:0] gotv);
      assert (gotv === expv) else begin
         value_errors++;
         $display("ERR %0t %s expected %h got %h", $time, name, expv, gotv);
      end
   endtask

   // index of the nth packet of queue q in phase ph, -1 when there is none
   function automatic int find_packet(input int ph, input int q, input int nth);
      int seen;
      seen = 0;
      foreach (pkt_phase[i]) begin
         if (pkt_phase[i] == ph && pkt_queue[i] == q) begin
            if (seen == nth) return i;
            seen++;
         end
      end
      return -1;
   endfunction

   task automatic load_stimulus(output bit ok);
      int               fd;
      int               ph;
      int               q;
      int               nb;
      int               cnt;
      tdata_t           first;
      tstrb_t           strb;
      logic [63:0]      tag;
      logic [8*160-1:0] rest;
      ok = 1'b1;
      fd = $fopen("testbench/stimulus_packets.txt", "r");
      if (fd == 0) begin
         ok = 1'b0;
         return;
      end
      while (ok && $fscanf(fd, "%s", tag) == 1) begin
         if (tag == "#") begin
            void'($fgets(rest, fd));
         end else if (tag == "P") begin
            if ($fscanf(fd, "%d %d %d %h %h", ph, q, nb, first, strb) != 5) ok = 1'b0;
            if (q < 0 || q >= NUM_QUEUES || nb < 1) ok = 1'b0;
            pkt_phase.push_back(ph);
            pkt_queue.push_back(q);
            pkt_beats.push_back(nb);
            pkt_first.push_back(first);
            pkt_strb.push_back(strb);
            total_beats += nb;
            if (ph >= num_phases) num_phases = ph + 1;
         end else if (tag == "E") begin
            if ($fscanf(fd, "%d %d", ph, cnt) != 2) ok = 1'b0;
            for (int i = 0; i < cnt && ok; i++) begin
               if ($fscanf(fd, "%d", q) != 1) ok = 1'b0;
               ord_phase.push_back(ph);
               ord_queue.push_back(q);
            end
         end else begin
            ok = 1'b0;
         end
      end
      $fclose(fd);
   endtask

   // one beat per accepted handshake, data counts up from the first word
   task automatic send_packet(input int i);
      int q;
      q = pkt_queue[i];
      for (int b = 0; b < pkt_beats[i]; b++) begin
         s_axis_tdata[q]  <= pkt_first[i] + tdata_t'(b);
         s_axis_tstrb[q]  <= (b == pkt_beats[i] - 1) ? pkt_strb[i] : {TSTRB_W{1'b1}};
         s_axis_tuser[q]  <= tuser_t'(q);
         s_axis_tlast[q]  <= (b == pkt_beats[i] - 1);
         s_axis_tvalid[q] <= 1'b1;
         do begin
            @(posedge axi_aclk);
         end while (!s_axis_tready[q]);
      end
      s_axis_tvalid[q] <= 1'b0;
      s_axis_tlast[q]  <= 1'b0;
   endtask

   task automatic drain_beats();
      int     n;
      logic   stalled;
      logic   late_valid;
      tdata_t hold_data;
      tstrb_t hold_strb;
      tuser_t hold_user;
      logic   hold_last;
      n       = 0;
      stalled = 1'b0;
      while (n < exp_data.size()) begin
         lfsr_state = lfsr_next(lfsr_state);
         m_axis_tready <= lfsr_state[0];
         @(posedge axi_aclk);
         if (stalled) begin
            assert (m_axis_tvalid) else begin
               protocol_errors++;
               $display("%0t m_axis_tvalid dropped while a beat was stalled", $time);
            end
            compare_value("m_axis_tdata (stalled)", hold_data, m_axis_tdata);
            compare_value("m_axis_tstrb (stalled)", 64'(hold_strb), 64'(m_axis_tstrb));
            compare_value("m_axis_tuser (stalled)", 64'(hold_user), 64'(m_axis_tuser));
            compare_value("m_axis_tlast (stalled)", 64'(hold_last), 64'(m_axis_tlast));
         end
         stalled   = m_axis_tvalid && !m_axis_tready;
         hold_data = m_axis_tdata;
         hold_strb = m_axis_tstrb;
         hold_user = m_axis_tuser;
         hold_last = m_axis_tlast;
         if (m_axis_tvalid && m_axis_tready) begin
            compare_value("m_axis_tdata", exp_data[n], m_axis_tdata);
            compare_value("m_axis_tstrb", 64'(exp_strb[n]), 64'(m_axis_tstrb));
            compare_value("m_axis_tuser", 64'(exp_user[n]), 64'(m_axis_tuser));
            compare_value("m_axis_tlast", 64'(exp_last[n]), 64'(m_axis_tlast));
            n++;
         end
      end
      m_axis_tready <= 1'b0;
      // long enough for the arbiter to scan every queue once
      late_valid = 1'b0;
      repeat (NUM_QUEUES + 2) begin
         @(posedge axi_aclk);
         late_valid = late_valid | m_axis_tvalid;
      end
      assert (!late_valid) else begin
         protocol_errors++;
         $display("%0t master stream offered beats beyond the expected packets", $time);
      end
   endtask

   task automatic run_phase(input int ph);
      int order [$];
      int fill  [NUM_QUEUES];
      int taken [NUM_QUEUES];
      int idx;
      foreach (fill[q]) begin
         fill[q]  = 0;
         taken[q] = 0;
      end
      foreach (ord_phase[k]) begin
         if (ord_phase[k] == ph) order.push_back(ord_queue[k]);
      end
      assert (order.size() > 0) else begin
         protocol_errors++;
         $display("phase %0d has no expected-order line", ph);
      end
      if (order.size() == 0) return;
      // lead queue goes in alone so the arbiter locks onto it
      foreach (pkt_phase[i]) begin
         if (pkt_phase[i] == ph && pkt_queue[i] == order[0]) send_packet(i);
      end
      while (!m_axis_tvalid) @(posedge axi_aclk);
      foreach (pkt_phase[i]) begin
         if (pkt_phase[i] == ph && pkt_queue[i] != order[0]) send_packet(i);
         if (pkt_phase[i] == ph) fill[pkt_queue[i]] += pkt_beats[i];
      end
      @(posedge axi_aclk);  // occupancy settles
      for (int q = 0; q < NUM_QUEUES; q++) begin
         compare_value($sformatf("s_axis_tready[%0d]", q), 64'(fill[q] < DEPTH - 1),
                       64'(s_axis_tready[q]));
      end
      exp_data.delete();
      exp_strb.delete();
      exp_user.delete();
      exp_last.delete();
      foreach (order[k]) begin
         idx = find_packet(ph, order[k], taken[order[k]]);
         assert (idx >= 0) else begin
            protocol_errors++;
            $display("phase %0d expects a packet from queue %0d that was never sent",
                     ph, order[k]);
         end
         if (idx >= 0) begin
            taken[order[k]]++;
            for (int b = 0; b < pkt_beats[idx]; b++) begin
               exp_data.push_back(pkt_first[idx] + tdata_t'(b));
               exp_strb.push_back((b == pkt_beats[idx] - 1) ? pkt_strb[idx] : {TSTRB_W{1'b1}});
               exp_user.push_back(tuser_t'(order[k]));
               exp_last.push_back(b == pkt_beats[idx] - 1);
            end
         end
      end
      drain_beats();
   endtask

   initial begin : main
      bit file_ok;
      for (int q = 0; q < NUM_QUEUES; q++) begin
         s_axis_tdata[q]  <= '0;
         s_axis_tstrb[q]  <= '0;
         s_axis_tuser[q]  <= '0;
         s_axis_tvalid[q] <= 1'b0;
         s_axis_tlast[q]  <= 1'b0;
      end
      m_axis_tready <= 1'b0;
      load_stimulus(file_ok);
      if (!file_ok) begin
         $display("stimulus file testbench/stimulus_packets.txt is missing or malformed");
         $display("Verification failed");
         $finish;
      end else begin
         cycle_limit = 20 * total_beats + 500;
         @(posedge axi_resetn);
         @(posedge axi_aclk);
         compare_value("m_axis_tvalid", 64'(0), 64'(m_axis_tvalid));
         for (int q = 0; q < NUM_QUEUES; q++) begin
            compare_value($sformatf("s_axis_tready[%0d]", q), 64'(1), 64'(s_axis_tready[q]));
         end
         for (int ph = 0; ph < num_phases; ph++) begin
            run_phase(ph);
         end
         $display("closing count %0d value errors %0d protocol errors",
                  value_errors, protocol_errors);
         if (value_errors == 0 && protocol_errors == 0) begin
            $display("Verification passed");
         end else begin
            $display("Verification failed");
         end
         $finish;
      end
   end

endmodule

`default_nettype wire

//--- testbench/tb_clock_gen.sv
//******************************
// free-running clock and synchronous active-low reset
// reset releases on a rising edge after RESET_CYCLES edges
//******************************
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen #(
   parameter int PERIOD_NS    = 4,
   parameter int RESET_CYCLES = 8
)
(
   output logic axi_aclk,
   output logic axi_resetn
);

   initial begin
      axi_aclk = 1'b0;
      forever #(PERIOD_NS / 2) axi_aclk = ~axi_aclk;
   end

   initial begin
      axi_resetn = 1'b0;
      repeat (RESET_CYCLES) @(posedge axi_aclk);
      axi_resetn <= 1'b1;  // DUT sees it one edge later
   end

endmodule

`default_nettype wire

//--- source/ualink_aggregator_top.sv
//******************************
// NUM_QUEUES slave streams merged onto one master stream
// whole packets only, queues served in round-robin order
//******************************
`timescale 1ns/10ps
`default_nettype none

module ualink_aggregator_top
   import turbo_pkg::*;
#(
   parameter int NUM_QUEUES      = 5,
   parameter int FIFO_DEPTH_BITS = 4   // 16 words per queue
)
(
   input  logic   axi_aclk,
   input  logic   axi_resetn,

   // slave stream ports, one per queue
   input  tdata_t s_axis_tdata  [NUM_QUEUES],
   input  tstrb_t s_axis_tstrb  [NUM_QUEUES],
   input  tuser_t s_axis_tuser  [NUM_QUEUES],
   input  logic   s_axis_tvalid [NUM_QUEUES],
   output logic   s_axis_tready [NUM_QUEUES],
   input  logic   s_axis_tlast  [NUM_QUEUES],

   // master stream port
   output tdata_t m_axis_tdata,
   output tstrb_t m_axis_tstrb,
   output tuser_t m_axis_tuser,
   output logic   m_axis_tvalid,
   input  logic   m_axis_tready,
   output logic   m_axis_tlast
);

   // queue heads toward the arbiter
   wire tdata_t q_tdata [NUM_QUEUES];
   wire tstrb_t q_tstrb [NUM_QUEUES];
   wire tuser_t q_tuser [NUM_QUEUES];
   wire logic   q_tlast [NUM_QUEUES];
   wire logic   q_empty [NUM_QUEUES];
   wire logic   q_pop   [NUM_QUEUES];  // from the arbiter

   for (genvar i = 0; i < NUM_QUEUES; i++) begin : g_queue
      ingress_fifo #(
         .FIFO_DEPTH_BITS (FIFO_DEPTH_BITS)
      ) i_ingress_fifo (
         .axi_aclk      (axi_aclk),
         .axi_resetn    (axi_resetn),
         .s_axis_tdata  (s_axis_tdata[i]),
         .s_axis_tstrb  (s_axis_tstrb[i]),
         .s_axis_tuser  (s_axis_tuser[i]),
         .s_axis_tvalid (s_axis_tvalid[i]),
         .s_axis_tready (s_axis_tready[i]),
         .s_axis_tlast  (s_axis_tlast[i]),
         .q_tdata       (q_tdata[i]),
         .q_tstrb       (q_tstrb[i]),
         .q_tuser       (q_tuser[i]),
         .q_tlast       (q_tlast[i]),
         .q_empty       (q_empty[i]),
         .q_pop         (q_pop[i])
      );
   end

   egress_arbiter #(
      .NUM_QUEUES (NUM_QUEUES)
   ) i_egress_arbiter (
      .axi_aclk      (axi_aclk),
      .axi_resetn    (axi_resetn),
      .q_tdata       (q_tdata),
      .q_tstrb       (q_tstrb),
      .q_tuser       (q_tuser),
      .q_tlast       (q_tlast),
      .q_empty       (q_empty),
      .q_pop         (q_pop),
      .m_axis_tdata  (m_axis_tdata),
      .m_axis_tstrb  (m_axis_tstrb),
      .m_axis_tuser  (m_axis_tuser),
      .m_axis_tvalid (m_axis_tvalid),
      .m_axis_tready (m_axis_tready),
      .m_axis_tlast  (m_axis_tlast)
   );

endmodule

`default_nettype wire

//--- source/egress_arbiter.sv
//******************************
// round-robin over the queues, one whole packet per turn
// packets never interleave, a queue keeps the port until tlast
// NUM_QUEUES must be 2 or more
//******************************
`timescale 1ns/10ps
`default_nettype none

module egress_arbiter
   import turbo_pkg::*;
#(
   parameter int NUM_QUEUES = 5
)
(
   input  logic   axi_aclk,
   input  logic   axi_resetn,

   // queue heads
   input  tdata_t q_tdata [NUM_QUEUES],
   input  tstrb_t q_tstrb [NUM_QUEUES],
   input  tuser_t q_tuser [NUM_QUEUES],
   input  logic   q_tlast [NUM_QUEUES],
   input  logic   q_empty [NUM_QUEUES],
   output logic   q_pop   [NUM_QUEUES],

   // master stream
   output tdata_t m_axis_tdata,
   output tstrb_t m_axis_tstrb,
   output tuser_t m_axis_tuser,
   output logic   m_axis_tvalid,
   input  logic   m_axis_tready,
   output logic   m_axis_tlast
);

   localparam int QW = $clog2(NUM_QUEUES);
   localparam logic [QW-1:0] LAST_QUEUE = QW'(NUM_QUEUES - 1);

   arb_state_t state;
   arb_state_t state_next;

   logic [QW-1:0]         cur_queue;
   logic [QW-1:0]         cur_queue_next;
   logic [QW-1:0]         cur_queue_plus1;
   logic                  cur_empty;
   logic                  xfer;      // beat accepted by the sink

   assign cur_queue_plus1 = (cur_queue == LAST_QUEUE) ? '0 : cur_queue + 1'b1;
   assign cur_empty       = q_empty[cur_queue];

   // selected head straight onto the master port
   assign m_axis_tdata  = q_tdata[cur_queue];
   assign m_axis_tstrb  = q_tstrb[cur_queue];
   assign m_axis_tuser  = q_tuser[cur_queue];
   assign m_axis_tlast  = q_tlast[cur_queue];
   assign m_axis_tvalid = (state == ARB_SEND) && !cur_empty;

   assign xfer = m_axis_tvalid && m_axis_tready;

   // pop only the owning queue, and only on a transfer
   for (genvar i = 0; i < NUM_QUEUES; i++) begin : g_pop
      assign q_pop[i] = xfer && (cur_queue == QW'(i));
   end

   always_comb begin
      state_next     = state;
      cur_queue_next = cur_queue;

      case (state)
         ARB_IDLE: begin
            // claim a queue with data, else move on
            if (!cur_empty) begin
               state_next = ARB_SEND;
            end else begin
               cur_queue_next = cur_queue_plus1;
            end
         end

         ARB_SEND: begin
            if (xfer && m_axis_tlast) begin  // end of packet, pass the turn
               state_next     = ARB_IDLE;
               cur_queue_next = cur_queue_plus1;
            end
         end

         default: begin
            state_next = ARB_IDLE;
         end
      endcase
   end

   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         state     <= ARB_IDLE;
         cur_queue <= '0;
      end else begin
         state     <= state_next;
         cur_queue <= cur_queue_next;
      end
   end

   // a stalled beat holds, which relies on the queue head staying put
   assert property (@(posedge axi_aclk) disable iff (!axi_resetn)
      (m_axis_tvalid && !m_axis_tready) |=>
         (m_axis_tvalid && $stable(m_axis_tdata) && $stable(m_axis_tstrb)
          && $stable(m_axis_tuser) && $stable(m_axis_tlast)))
      else $error("master stream changed while stalled");

endmodule

`default_nettype wire

//--- source/ingress_fifo.sv
//******************************
// fall-through input queue, head word shown without a read cycle
// tready drops at depth minus 1, so one slot always stays free
// q_pop must only be raised while q_empty is low
//******************************
`timescale 1ns/10ps
`default_nettype none

module ingress_fifo
   import turbo_pkg::*;
#(
   parameter int FIFO_DEPTH_BITS = 4
)
(
   input  logic   axi_aclk,
   input  logic   axi_resetn,

   // slave stream side
   input  tdata_t s_axis_tdata,
   input  tstrb_t s_axis_tstrb,
   input  tuser_t s_axis_tuser,
   input  logic   s_axis_tvalid,
   output logic   s_axis_tready,
   input  logic   s_axis_tlast,

   // arbiter side
   output tdata_t q_tdata,
   output tstrb_t q_tstrb,
   output tuser_t q_tuser,
   output logic   q_tlast,
   output logic   q_empty,
   input  logic   q_pop
);

   localparam int DEPTH = 1 << FIFO_DEPTH_BITS;
   localparam logic [FIFO_DEPTH_BITS:0] NEARLY_FULL_LVL = (FIFO_DEPTH_BITS + 1)'(DEPTH - 1);

   // beat storage, one entry per field
   tdata_t mem_tdata [DEPTH];
   tstrb_t mem_tstrb [DEPTH];
   tuser_t mem_tuser [DEPTH];
   logic   mem_tlast [DEPTH];

   logic [FIFO_DEPTH_BITS-1:0] wr_ptr;
   logic [FIFO_DEPTH_BITS-1:0] rd_ptr;
   logic [FIFO_DEPTH_BITS:0]   count;   // occupancy, 0 to DEPTH-1 in practice
   logic                       nearly_full;
   logic                       push;

   assign nearly_full   = (count >= NEARLY_FULL_LVL);
   assign s_axis_tready = ~nearly_full;  // independent of tvalid
   assign push          = s_axis_tvalid & s_axis_tready;
   assign q_empty       = (count == '0);

   // head of queue, fall-through
   assign q_tdata = mem_tdata[rd_ptr];
   assign q_tstrb = mem_tstrb[rd_ptr];
   assign q_tuser = mem_tuser[rd_ptr];
   assign q_tlast = mem_tlast[rd_ptr];

   always_ff @(posedge axi_aclk) begin
      if (push) begin
         mem_tdata[wr_ptr] <= s_axis_tdata;
         mem_tstrb[wr_ptr] <= s_axis_tstrb;
         mem_tuser[wr_ptr] <= s_axis_tuser;
         mem_tlast[wr_ptr] <= s_axis_tlast;
      end
   end

   // pointers wrap on their own, depth is a power of two
   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (q_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({push, q_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;  // idle, or push and pop together
         endcase
      end
   end

   // arbiter never pops a queue that holds nothing
   assert property (@(posedge axi_aclk) disable iff (!axi_resetn)
      q_pop |-> !q_empty)
      else $error("pop on empty ingress queue");

endmodule

`default_nettype wire

//--- source/turbo_pkg.sv
//******************************
// stream field widths and types shared by the aggregator
// tstrb width follows tdata, one strobe per byte
//******************************
`default_nettype none

package turbo_pkg;

   // beat payload widths
   localparam int TDATA_W = 64;
   localparam int TUSER_W = 32;
   localparam int TSTRB_W = TDATA_W / 8;  // one strobe per data byte

   // one word of stream data
   typedef logic [TDATA_W-1:0] tdata_t;

   // byte strobes that go with tdata_t
   typedef logic [TSTRB_W-1:0] tstrb_t;

   // sideband metadata, carried through untouched
   typedef logic [TUSER_W-1:0] tuser_t;

   // egress arbiter FSM
   typedef enum logic [0:0] {
      ARB_IDLE = 1'b0,  // scanning queues
      ARB_SEND = 1'b1   // forwarding one packet
   } arb_state_t;

endpackage

`default_nettype wire
